// File: rtl/nb_cache_pkg.sv
// Geometry, field types, packet structs and FSM encodings of the
// non-blocking read-only cache. Imported by every RTL module.
package nb_cache_pkg;

  localparam int ADDR_WIDTH  = 12;
  localparam int DATA_WIDTH  = 32;
  localparam int ID_WIDTH    = 4;
  localparam int SETS        = 16;
  localparam int BLOCK_WORDS = 4;

  // Word address split as {tag, index, offset}
  localparam int OFFSET_WIDTH = $clog2(BLOCK_WORDS);
  localparam int INDEX_WIDTH  = $clog2(SETS);
  localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

  typedef logic [ADDR_WIDTH-1:0]   addr_t;
  typedef logic [DATA_WIDTH-1:0]   data_t;
  typedef logic [ID_WIDTH-1:0]     id_t;
  typedef logic [INDEX_WIDTH-1:0]  index_t;
  typedef logic [OFFSET_WIDTH-1:0] offset_t;
  typedef logic [TAG_WIDTH-1:0]    tag_t;

  // Load request, also the miss FIFO entry
  typedef struct packed {
    id_t   id;
    addr_t addr;
  } cache_req_s;

  typedef struct packed {
    logic    write;
    index_t  index;
    offset_t offset;
    data_t   data;
  } data_pkt_s;

  typedef struct packed {
    tag_t   tag;
    index_t index;
  } refill_cmd_s;

  typedef enum logic [1:0] {mhu_idle, mhu_probe, mhu_refill_wait, mhu_read} mhu_state_e;
  typedef enum logic [1:0] {dma_idle, dma_send, dma_recv} dma_state_e;

endpackage

// File: rtl/nb_cache_tag_lookup.sv
// Tag lookup stage. Holds one request, checks it against the tag and
// valid arrays, then sends it to the data array or the miss FIFO.
// The MHU probes, invalidates and fills lines through a side port.
`timescale 1ns/1ps

module nb_cache_tag_lookup (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     v_i,
  input  nb_cache_pkg::cache_req_s req_i,
  output logic                     ready_o,
  input  logic                     read_grant_i,
  output logic                     read_v_o,
  output nb_cache_pkg::data_pkt_s  read_pkt_o,
  output nb_cache_pkg::id_t        read_id_o,
  input  logic                     miss_ready_i,
  output logic                     miss_v_o,
  output nb_cache_pkg::cache_req_s miss_entry_o,
  input  nb_cache_pkg::addr_t      probe_addr_i,
  input  logic                     inval_v_i,
  input  logic                     fill_v_i,
  output logic                     probe_hit_o
);
  import nb_cache_pkg::*;

  logic       req_v_r;
  cache_req_s req_r;
  logic [SETS-1:0] valid_r;
  tag_t       tag_r [SETS];

  index_t req_index, probe_index;
  tag_t   req_tag, probe_tag;
  logic   hit, done;

  assign req_index   = req_r.addr[OFFSET_WIDTH +: INDEX_WIDTH];
  assign req_tag     = req_r.addr[ADDR_WIDTH-1 -: TAG_WIDTH];
  assign probe_index = probe_addr_i[OFFSET_WIDTH +: INDEX_WIDTH];
  assign probe_tag   = probe_addr_i[ADDR_WIDTH-1 -: TAG_WIDTH];

  // Re-evaluated every cycle, so a held request sees MHU line updates
  assign hit         = valid_r[req_index] && (tag_r[req_index] == req_tag);
  assign probe_hit_o = valid_r[probe_index] && (tag_r[probe_index] == probe_tag);

  assign read_v_o   = req_v_r & hit;
  assign read_pkt_o = '{write: 1'b0, index: req_index,
                        offset: req_r.addr[OFFSET_WIDTH-1:0], data: '0};
  assign read_id_o  = req_r.id;

  assign miss_v_o     = req_v_r & ~hit;
  assign miss_entry_o = req_r;

  assign done    = hit ? read_grant_i : miss_ready_i;
  assign ready_o = ~req_v_r | done;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_v_r <= 1'b0;
      valid_r <= '0;
    end else begin
      if (ready_o) begin
        req_v_r <= v_i;
      end
      if (inval_v_i) begin
        valid_r[probe_index] <= 1'b0;
      end else if (fill_v_i) begin
        valid_r[probe_index] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ready_o && v_i) begin
      req_r <= req_i;
    end
    if (fill_v_i) begin
      tag_r[probe_index] <= probe_tag;
    end
  end

  // MHU never invalidates and fills a line in the same cycle
  assert property (@(posedge clk_i) disable iff (reset_i) !(inval_v_i && fill_v_i));

endmodule

// File: rtl/nb_cache_miss_fifo.sv
// In-order queue of missed requests between tag lookup and the MHU.
// Circular buffer of els_p entries with a valid/ready push side.
`timescale 1ns/1ps

module nb_cache_miss_fifo #(
  parameter int els_p = 4
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     v_i,
  input  nb_cache_pkg::cache_req_s entry_i,
  output logic                     ready_o,
  output logic                     v_o,
  output nb_cache_pkg::cache_req_s entry_o,
  input  logic                     yumi_i
);
  import nb_cache_pkg::*;

  localparam int ptr_width_lp   = (els_p > 1) ? $clog2(els_p) : 1;
  localparam int count_width_lp = $clog2(els_p + 1);

  cache_req_s mem_r [els_p];
  logic [ptr_width_lp-1:0]   rd_ptr_r, wr_ptr_r;
  logic [count_width_lp-1:0] count_r;
  logic push;

  assign ready_o = (count_r != count_width_lp'(els_p));
  assign v_o     = (count_r != '0);
  assign entry_o = mem_r[rd_ptr_r];
  assign push    = v_i & ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_r <= '0;
      wr_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push) begin
        wr_ptr_r <= (wr_ptr_r == ptr_width_lp'(els_p - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (yumi_i) begin
        rd_ptr_r <= (rd_ptr_r == ptr_width_lp'(els_p - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      case ({push, yumi_i})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wr_ptr_r] <= entry_i;
    end
  end

  // A miss refused while full is offered again unchanged
  assert property (@(posedge clk_i) disable iff (reset_i)
    v_i && !ready_o |=> $stable(entry_i));
  assert property (@(posedge clk_i) disable iff (reset_i) yumi_i |-> v_o);

endmodule

// File: rtl/nb_cache_mhu.sv
// Miss handling unit. Serves the miss FIFO head one at a time:
// probe the line, refill it if absent, then read the word out.
`timescale 1ns/1ps

module nb_cache_mhu (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      head_v_i,
  input  nb_cache_pkg::cache_req_s  head_i,
  output logic                      head_yumi_o,
  output nb_cache_pkg::addr_t       probe_addr_o,
  input  logic                      probe_hit_i,
  output logic                      inval_v_o,
  output logic                      fill_v_o,
  output logic                      refill_v_o,
  output nb_cache_pkg::refill_cmd_s refill_cmd_o,
  input  logic                      refill_done_i,
  output logic                      read_v_o,
  output nb_cache_pkg::data_pkt_s   read_pkt_o,
  output nb_cache_pkg::id_t         read_id_o,
  input  logic                      read_grant_i
);
  import nb_cache_pkg::*;

  mhu_state_e state_r, state_n;

  assign probe_addr_o = head_i.addr;
  assign refill_cmd_o = '{tag: head_i.addr[ADDR_WIDTH-1 -: TAG_WIDTH],
                          index: head_i.addr[OFFSET_WIDTH +: INDEX_WIDTH]};
  assign read_pkt_o   = '{write: 1'b0, index: head_i.addr[OFFSET_WIDTH +: INDEX_WIDTH],
                          offset: head_i.addr[OFFSET_WIDTH-1:0], data: '0};
  assign read_id_o    = head_i.id;

  always_comb begin
    state_n     = state_r;
    inval_v_o   = 1'b0;
    fill_v_o    = 1'b0;
    refill_v_o  = 1'b0;
    read_v_o    = 1'b0;
    head_yumi_o = 1'b0;
    case (state_r)
      mhu_idle: begin
        if (head_v_i) state_n = mhu_probe;
      end
      mhu_probe: begin
        // Block may already be resident from an earlier miss
        if (probe_hit_i) begin
          state_n = mhu_read;
        end else begin
          inval_v_o  = 1'b1;
          refill_v_o = 1'b1;
          state_n    = mhu_refill_wait;
        end
      end
      mhu_refill_wait: begin
        if (refill_done_i) begin
          fill_v_o = 1'b1;
          state_n  = mhu_probe;
        end
      end
      mhu_read: begin
        read_v_o    = 1'b1;
        head_yumi_o = read_grant_i;
        if (read_grant_i) state_n = mhu_idle;
      end
      default: state_n = mhu_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= mhu_idle;
    end else begin
      state_r <= state_n;
    end
  end

endmodule

// File: rtl/nb_cache_dma.sv
// Refill engine. Sends one block request, then writes the returned
// words into the data array in offset order and reports done.
`timescale 1ns/1ps

module nb_cache_dma (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      cmd_v_i,
  input  nb_cache_pkg::refill_cmd_s cmd_i,
  output logic                      done_o,
  output nb_cache_pkg::addr_t       dma_addr_o,
  output logic                      dma_v_o,
  input  logic                      dma_yumi_i,
  input  nb_cache_pkg::data_t       dma_data_i,
  input  logic                      dma_data_v_i,
  output logic                      dma_data_ready_o,
  output logic                      write_v_o,
  output nb_cache_pkg::data_pkt_s   write_pkt_o
);
  import nb_cache_pkg::*;

  dma_state_e  state_r;
  refill_cmd_s cmd_r;
  offset_t     count_r;
  logic        done_r;

  assign dma_v_o          = (state_r == dma_send);
  assign dma_addr_o       = {cmd_r.tag, cmd_r.index, {OFFSET_WIDTH{1'b0}}};
  assign dma_data_ready_o = (state_r == dma_recv);
  assign done_o           = done_r;

  assign write_v_o   = dma_data_ready_o & dma_data_v_i;
  assign write_pkt_o = '{write: 1'b1, index: cmd_r.index, offset: count_r, data: dma_data_i};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= dma_idle;
      count_r <= '0;
      done_r  <= 1'b0;
    end else begin
      done_r <= 1'b0;
      case (state_r)
        dma_idle: if (cmd_v_i) state_r <= dma_send;
        dma_send: begin
          if (dma_yumi_i) begin
            state_r <= dma_recv;
            count_r <= '0;
          end
        end
        dma_recv: begin
          if (dma_data_v_i) begin
            count_r <= count_r + 1'b1;
            if (count_r == offset_t'(BLOCK_WORDS - 1)) begin
              state_r <= dma_idle;
              done_r  <= 1'b1;
            end
          end
        end
        default: state_r <= dma_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_r == dma_idle && cmd_v_i) begin
      cmd_r <= cmd_i;
    end
  end

  // Memory side streams words only after the block request was taken
  assert property (@(posedge clk_i) disable iff (reset_i) dma_data_v_i |-> state_r == dma_recv);

endmodule

// File: rtl/nb_cache_data_array.sv
// Data storage with fixed-priority access: DMA writes, then MHU reads,
// then tag lookup reads. Read results land in the response register,
// which holds while the consumer withholds yumi.
`timescale 1ns/1ps

module nb_cache_data_array (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    dma_write_v_i,
  input  nb_cache_pkg::data_pkt_s dma_write_pkt_i,
  input  logic                    mhu_read_v_i,
  input  nb_cache_pkg::data_pkt_s mhu_read_pkt_i,
  input  nb_cache_pkg::id_t       mhu_read_id_i,
  input  logic                    tl_read_v_i,
  input  nb_cache_pkg::data_pkt_s tl_read_pkt_i,
  input  nb_cache_pkg::id_t       tl_read_id_i,
  output logic                    mhu_grant_o,
  output logic                    tl_grant_o,
  output logic                    v_o,
  output nb_cache_pkg::id_t       id_o,
  output nb_cache_pkg::data_t     data_o,
  input  logic                    yumi_i
);
  import nb_cache_pkg::*;

  data_t     mem_r [SETS*BLOCK_WORDS];
  logic      v_r;
  id_t       id_r;
  data_t     data_r;
  logic      stall;
  data_pkt_s rd_pkt;
  id_t       rd_id;

  // Unconsumed response blocks all reads, DMA keeps going
  assign stall = v_r & ~yumi_i;

  assign mhu_grant_o = mhu_read_v_i & ~dma_write_v_i & ~stall;
  assign tl_grant_o  = tl_read_v_i & ~mhu_read_v_i & ~dma_write_v_i & ~stall;

  assign rd_pkt = mhu_grant_o ? mhu_read_pkt_i : tl_read_pkt_i;
  assign rd_id  = mhu_grant_o ? mhu_read_id_i : tl_read_id_i;

  always_ff @(posedge clk_i) begin
    if (dma_write_v_i && dma_write_pkt_i.write) begin
      mem_r[{dma_write_pkt_i.index, dma_write_pkt_i.offset}] <= dma_write_pkt_i.data;
    end
    if (!stall) begin
      id_r   <= rd_id;
      data_r <= mem_r[{rd_pkt.index, rd_pkt.offset}];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_r <= 1'b0;
    end else if (!stall) begin
      v_r <= mhu_grant_o | tl_grant_o;
    end
  end

  assign v_o    = v_r;
  assign id_o   = id_r;
  assign data_o = data_r;

endmodule

// File: rtl/nb_cache.sv
// Non-blocking read-only direct-mapped cache.
// Hits are served in fixed time, misses queue up and return later by id.
`timescale 1ns/1ps

module nb_cache #(
  parameter int miss_fifo_els_p = 4
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     v_i,
  input  nb_cache_pkg::cache_req_s cache_req_i,
  output logic                     ready_o,
  output logic                     v_o,
  output nb_cache_pkg::id_t        id_o,
  output nb_cache_pkg::data_t      data_o,
  input  logic                     yumi_i,
  output nb_cache_pkg::addr_t      dma_addr_o,
  output logic                     dma_v_o,
  input  logic                     dma_yumi_i,
  input  nb_cache_pkg::data_t      dma_data_i,
  input  logic                     dma_data_v_i,
  output logic                     dma_data_ready_o
);
  import nb_cache_pkg::*;

  logic        tl_read_v, tl_grant, miss_v, miss_ready, probe_hit;
  data_pkt_s   tl_read_pkt;
  id_t         tl_read_id;
  cache_req_s  miss_entry, head;
  logic        head_v, head_yumi;
  addr_t       probe_addr;
  logic        inval_v, fill_v, refill_v, refill_done;
  refill_cmd_s refill_cmd;
  logic        mhu_read_v, mhu_grant;
  data_pkt_s   mhu_read_pkt;
  id_t         mhu_read_id;
  logic        dma_write_v;
  data_pkt_s   dma_write_pkt;

  nb_cache_tag_lookup tl0 (
    .clk_i, .reset_i, .v_i, .req_i(cache_req_i), .ready_o,
    .read_grant_i(tl_grant), .read_v_o(tl_read_v), .read_pkt_o(tl_read_pkt),
    .read_id_o(tl_read_id), .miss_ready_i(miss_ready), .miss_v_o(miss_v),
    .miss_entry_o(miss_entry), .probe_addr_i(probe_addr), .inval_v_i(inval_v),
    .fill_v_i(fill_v), .probe_hit_o(probe_hit)
  );

  nb_cache_miss_fifo #(.els_p(miss_fifo_els_p)) miss_fifo0 (
    .clk_i, .reset_i, .v_i(miss_v), .entry_i(miss_entry), .ready_o(miss_ready),
    .v_o(head_v), .entry_o(head), .yumi_i(head_yumi)
  );

  nb_cache_mhu mhu0 (
    .clk_i, .reset_i, .head_v_i(head_v), .head_i(head), .head_yumi_o(head_yumi),
    .probe_addr_o(probe_addr), .probe_hit_i(probe_hit), .inval_v_o(inval_v),
    .fill_v_o(fill_v), .refill_v_o(refill_v), .refill_cmd_o(refill_cmd),
    .refill_done_i(refill_done), .read_v_o(mhu_read_v), .read_pkt_o(mhu_read_pkt),
    .read_id_o(mhu_read_id), .read_grant_i(mhu_grant)
  );

  nb_cache_dma dma0 (
    .clk_i, .reset_i, .cmd_v_i(refill_v), .cmd_i(refill_cmd), .done_o(refill_done),
    .dma_addr_o, .dma_v_o, .dma_yumi_i, .dma_data_i, .dma_data_v_i, .dma_data_ready_o,
    .write_v_o(dma_write_v), .write_pkt_o(dma_write_pkt)
  );

  nb_cache_data_array data_array0 (
    .clk_i, .reset_i, .dma_write_v_i(dma_write_v), .dma_write_pkt_i(dma_write_pkt),
    .mhu_read_v_i(mhu_read_v), .mhu_read_pkt_i(mhu_read_pkt), .mhu_read_id_i(mhu_read_id),
    .tl_read_v_i(tl_read_v), .tl_read_pkt_i(tl_read_pkt), .tl_read_id_i(tl_read_id),
    .mhu_grant_o(mhu_grant), .tl_grant_o(tl_grant), .v_o, .id_o, .data_o, .yumi_i
  );

endmodule

// File: testbench/tb_mem_model.sv
// Refill memory behind the cache DMA port. Takes one block request,
// answers after a fixed delay with one word per offset in order, and
// counts the requests it has seen. Word at address a is a ^ 32'ha5a50000.
`timescale 1ns/1ps

module tb_mem_model #(
  parameter int delay_p = 20
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  nb_cache_pkg::addr_t dma_addr_i,
  input  logic                dma_v_i,
  output logic                dma_yumi_o,
  output nb_cache_pkg::data_t dma_data_o,
  output logic                dma_data_v_o,
  input  logic                dma_data_ready_i,
  output int                  req_count_o,
  output nb_cache_pkg::addr_t last_addr_o
);
  import nb_cache_pkg::*;

  addr_t base;

  initial begin
    dma_yumi_o   = 1'b0;
    dma_data_o   = '0;
    dma_data_v_o = 1'b0;
    req_count_o  = 0;
    last_addr_o  = '0;
    forever begin
      @(negedge clk_i);
      if (!reset_i && dma_v_i) begin
        base        = dma_addr_i;
        last_addr_o = base;
        req_count_o = req_count_o + 1;
        // Request taken one cycle after it shows up
        @(posedge clk_i);
        #1 dma_yumi_o = 1'b1;
        @(posedge clk_i);
        #1 dma_yumi_o = 1'b0;
        repeat (delay_p) @(posedge clk_i);
        #1;
        for (int w = 0; w < BLOCK_WORDS; w++) begin
          dma_data_v_o = 1'b1;
          dma_data_o   = data_t'(base + addr_t'(w)) ^ 32'ha5a50000;
          @(negedge clk_i);
          while (!dma_data_ready_i) @(negedge clk_i);
          @(posedge clk_i);
          #1;
        end
        dma_data_v_o = 1'b0;
      end
    end
  end

endmodule

// File: testbench/tb_nb_cache.sv
// Testbench for the non-blocking cache. Directed tests for reset, cold
// miss, hit latency, hit under miss and merged misses, then a random
// load stream with back-pressure. Responses are checked by id.
`timescale 1ns/1ps

module tb_nb_cache;
  import nb_cache_pkg::*;

  localparam int          clk_period_lp     = 8;
  localparam int          mem_delay_lp      = 20;
  localparam logic [31:0] seed_lp           = 32'hbe1785f8;
  localparam int          random_loads_lp   = 200;
  localparam int          directed_loads_lp = 8;
  // Slowest load waits for a whole refill, margin for random stalls
  localparam int          miss_cycles_lp    = mem_delay_lp + 16;
  localparam int          watchdog_ns_lp    =
    (random_loads_lp + directed_loads_lp) * miss_cycles_lp * 4 * clk_period_lp;

  logic       clk = 1'b0;
  logic       reset;
  logic       req_v, req_ready, resp_v, resp_yumi;
  cache_req_s req;
  id_t        resp_id;
  data_t      resp_data;
  addr_t      dma_addr, refill_addr;
  logic       dma_v, dma_yumi, dma_data_v, dma_data_ready;
  data_t      dma_data;
  int         refill_count;

  // Scoreboard, one slot per id
  data_t expected [16];
  logic  pending [16];
  int    accept_cycle [16];
  int    resp_cycle [16];
  int    resp_seq [16];
  int    pending_count = 0;
  int    resp_total = 0;
  int    cycle_count = 0;

  logic        hold_v = 1'b0;
  id_t         hold_id;
  data_t       hold_data;
  logic        random_yumi = 1'b0;
  logic [31:0] load_rng, yumi_rng;

  nb_cache #(.miss_fifo_els_p(4)) dut0 (
    .clk_i(clk), .reset_i(reset), .v_i(req_v), .cache_req_i(req), .ready_o(req_ready),
    .v_o(resp_v), .id_o(resp_id), .data_o(resp_data), .yumi_i(resp_yumi),
    .dma_addr_o(dma_addr), .dma_v_o(dma_v), .dma_yumi_i(dma_yumi), .dma_data_i(dma_data),
    .dma_data_v_i(dma_data_v), .dma_data_ready_o(dma_data_ready)
  );

  tb_mem_model #(.delay_p(mem_delay_lp)) mem0 (
    .clk_i(clk), .reset_i(reset), .dma_addr_i(dma_addr), .dma_v_i(dma_v),
    .dma_yumi_o(dma_yumi), .dma_data_o(dma_data), .dma_data_v_o(dma_data_v),
    .dma_data_ready_i(dma_data_ready), .req_count_o(refill_count), .last_addr_o(refill_addr)
  );

  always #(clk_period_lp / 2) clk = ~clk;

  always @(posedge clk) cycle_count <= cycle_count + 1;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic data_t memory_word(input addr_t addr);
    return data_t'(addr) ^ 32'ha5a50000;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic mismatch(input string msg);
    abort_run($sformatf("Mismatch at %0t ns: %s", $time, msg));
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic send_load(input id_t load_id, input addr_t load_addr);
    while (pending[load_id]) next_cycle();
    expected[load_id] = memory_word(load_addr);
    pending[load_id]  = 1'b1;
    pending_count++;
    req_v = 1'b1;
    req   = '{id: load_id, addr: load_addr};
    @(negedge clk);
    while (!req_ready) @(negedge clk);
    accept_cycle[load_id] = cycle_count + 1;
    next_cycle();
    req_v = 1'b0;
  endtask

  task automatic wait_idle();
    while (pending_count != 0) next_cycle();
    repeat (4) next_cycle();
  endtask

  // Response monitor, also checks that a stalled response holds
  always @(negedge clk) begin
    if (!reset) begin
      if (hold_v) begin
        assert (resp_v && resp_id == hold_id && resp_data == hold_data)
          else mismatch("response changed while yumi_i was low");
      end
      if (resp_v && resp_yumi) begin
        assert (pending[resp_id])
          else mismatch($sformatf("unexpected response for id %0d", resp_id));
        assert (resp_data == expected[resp_id])
          else mismatch($sformatf("id %0d data %h expected %h",
                                  resp_id, resp_data, expected[resp_id]));
        pending[resp_id] = 1'b0;
        pending_count--;
        resp_cycle[resp_id] = cycle_count + 1;
        resp_seq[resp_id]   = resp_total;
        resp_total++;
      end
      hold_v    = resp_v && !resp_yumi;
      hold_id   = resp_id;
      hold_data = resp_data;
    end
  end

  always @(posedge clk) begin
    #1;
    if (random_yumi) begin
      yumi_rng  = xorshift32(yumi_rng);
      resp_yumi = yumi_rng[0] | yumi_rng[1];
    end
  end

  task automatic check_reset_state();
    @(negedge clk);
    assert (!resp_v && !dma_v && !dma_data_ready)
      else mismatch("v_o, dma_v_o or dma_data_ready_o high after reset");
    assert (req_ready) else mismatch("ready_o low after reset");
    next_cycle();
  endtask

  task automatic cold_miss_refill();
    int refills;
    refills = refill_count;
    send_load(4'd1, 12'h041);
    wait_idle();
    assert (refill_count == refills + 1) else mismatch("cold miss refill count");
    assert (refill_addr == 12'h040)
      else mismatch($sformatf("refill address %h expected 040", refill_addr));
  endtask

  task automatic hit_after_refill();
    int refills;
    refills = refill_count;
    send_load(4'd2, 12'h043);
    wait_idle();
    assert (resp_cycle[2] - accept_cycle[2] == 2)
      else mismatch($sformatf("hit latency %0d edges", resp_cycle[2] - accept_cycle[2]));
    assert (refill_count == refills) else mismatch("hit caused a refill");
  endtask

  task automatic hit_overtakes_miss();
    int refills;
    refills = refill_count;
    // Index 4 misses, index 0 still holds block 040
    send_load(4'd3, 12'h092);
    send_load(4'd4, 12'h042);
    wait_idle();
    assert (resp_seq[4] < resp_seq[3]) else mismatch("hit did not overtake the miss");
    assert (refill_count == refills + 1) else mismatch("hit under miss refill count");
  endtask

  task automatic merged_block_misses();
    int refills;
    refills = refill_count;
    send_load(4'd5, 12'h0c1);
    send_load(4'd6, 12'h0c3);
    send_load(4'd7, 12'h0c0);
    wait_idle();
    assert (refill_count == refills + 1) else mismatch("one block refilled more than once");
    assert (resp_seq[5] < resp_seq[6] && resp_seq[6] < resp_seq[7])
      else mismatch("misses to one block left FIFO order");
  endtask

  task automatic random_backpressure_stream();
    logic [31:0] r;
    addr_t       addr;
    random_yumi = 1'b1;
    for (int i = 0; i < random_loads_lp; i++) begin
      load_rng = xorshift32(load_rng);
      r        = load_rng;
      // Two tags on each of four indexes, so blocks evict each other
      addr = {5'b00011, r[2], 2'b01, r[1:0], r[9:8]};
      send_load(id_t'(i), addr);
    end
    random_yumi = 1'b0;
    resp_yumi   = 1'b1;
    wait_idle();
  endtask

  initial begin
    #(watchdog_ns_lp);
    abort_run("Timeout: the tests did not finish within the watchdog limit");
  end

  initial begin
    reset     = 1'b1;
    req_v     = 1'b0;
    req       = '0;
    resp_yumi = 1'b1;
    load_rng  = seed_lp;
    yumi_rng  = xorshift32(seed_lp);
    for (int k = 0; k < 16; k++) begin
      pending[k]  = 1'b0;
      expected[k] = '0;
    end
    repeat (2) @(posedge clk);
    #1 reset = 1'b0;
    check_reset_state();
    cold_miss_refill();
    hit_after_refill();
    hit_overtakes_miss();
    merged_block_misses();
    random_backpressure_stream();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: list.f
rtl/nb_cache_pkg.sv
rtl/nb_cache_tag_lookup.sv
rtl/nb_cache_miss_fifo.sv
rtl/nb_cache_mhu.sv
rtl/nb_cache_dma.sv
rtl/nb_cache_data_array.sv
rtl/nb_cache.sv
testbench/tb_mem_model.sv
testbench/tb_nb_cache.sv

// File: run.sh
#!/bin/sh
# Build the cache testbench with Verilator and run it.
# The simulator exits non-zero when a check or the watchdog fires.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_nb_cache -f list.f
./obj_dir/Vtb_nb_cache
